// ==== source/deconv_pkg.sv ====
package deconv_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int FEATURE_SIZE = 2;
    localparam int WEIGHT_SIZE  = 3;
    localparam int STRIDE       = 1;
    localparam int NUM_KERNELS  = 4;
    localparam int PIX_WIDTH    = 16;
    localparam int N_PIX_OUT    = FEATURE_SIZE * WEIGHT_SIZE
                                - (WEIGHT_SIZE - STRIDE) * (FEATURE_SIZE - 1);
    localparam int ACC_WIDTH    = 2 * PIX_WIDTH;
    localparam int PIPE_DEPTH   = 2;

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------
    typedef logic signed [PIX_WIDTH-1:0] pix_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // Pixel 0 of a column sits in pix[0]
    typedef struct packed {
        pix_t [FEATURE_SIZE-1:0] pix;
    } fcol_t;

    typedef struct packed {
        pix_t [WEIGHT_SIZE-1:0] tap;
    } wcol_t;

    // Kernel n feeds core n
    typedef struct packed {
        wcol_t [NUM_KERNELS-1:0] kern;
    } weight_set_t;

    typedef struct packed {
        acc_t [N_PIX_OUT-1:0] acc;
    } dcol_t;

    typedef struct packed {
        dcol_t [NUM_KERNELS-1:0] kern;
    } deconv_result_t;

    typedef enum logic {
        WAIT_WEIGHTS,
        RUN
    } ctrl_state_e;

endpackage

// ==== source/feature_pingpong_buffer.sv ====
`timescale 1ns/1ps

module feature_pingpong_buffer
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_feat_valid,
    input  deconv_pkg::pix_t    i_feat_data,
    output logic                o_feat_ready,
    input  logic                i_col_release,
    output logic                o_col_avail,
    output deconv_pkg::fcol_t   o_col
);

    deconv_pkg::fcol_t                              bank_q [2];
    logic [1:0]                                     full_q;
    logic                                           wr_ptr_q;
    logic                                           rd_ptr_q;
    logic [$clog2(deconv_pkg::FEATURE_SIZE)-1:0]    pix_idx_q;
    logic                                           wr_fire;

    assign o_feat_ready = !full_q[wr_ptr_q];
    assign wr_fire      = i_feat_valid && o_feat_ready;

    // Oldest full bank faces the cores
    assign o_col_avail  = full_q[rd_ptr_q];
    assign o_col        = bank_q[rd_ptr_q];

    // --------------------------------------------------
    // Column assembly
    // --------------------------------------------------
    // New pixel enters at the top and older ones move down,
    // so pixel 0 lands in pix[0] once the column is complete
    always_ff @(posedge i_clk)
    begin
        if (wr_fire)
        begin
            bank_q[wr_ptr_q].pix <= {i_feat_data,
                                     bank_q[wr_ptr_q].pix[deconv_pkg::FEATURE_SIZE-1:1]};
        end
    end

    // --------------------------------------------------
    // Bank flags and pointers
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            full_q    <= '0;
            wr_ptr_q  <= 1'b0;
            rd_ptr_q  <= 1'b0;
            pix_idx_q <= '0;
        end
        else
        begin
            if (wr_fire)
            begin
                if (pix_idx_q == deconv_pkg::FEATURE_SIZE - 1)
                begin
                    full_q[wr_ptr_q] <= 1'b1;
                    wr_ptr_q         <= !wr_ptr_q;
                    pix_idx_q        <= '0;
                end
                else
                begin
                    pix_idx_q <= pix_idx_q + 1'b1;
                end
            end

            // Never the bank being filled, that one is not full
            if (i_col_release)
            begin
                full_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q         <= !rd_ptr_q;
            end
        end
    end

    a_release_when_avail: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_col_release |-> o_col_avail
    ) else $error("column released from an empty bank");

endmodule

// ==== source/weight_bank.sv ====
`timescale 1ns/1ps

module weight_bank
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_wgt_valid,
    input  deconv_pkg::weight_set_t     i_wgt_data,
    input  logic                        i_wgt_open,
    output logic                        o_wgt_ready,
    output logic                        o_loaded,
    output deconv_pkg::weight_set_t     o_weights
);

    deconv_pkg::weight_set_t    wgt_q;
    logic                       loaded_q;
    logic                       wr_fire;

    assign o_wgt_ready = i_wgt_open;
    assign wr_fire     = i_wgt_valid && i_wgt_open;

    always_ff @(posedge i_clk)
    begin
        if (wr_fire)
        begin
            wgt_q <= i_wgt_data;
        end
    end

    // Sticky until reset
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            loaded_q <= 1'b0;
        end
        else if (wr_fire)
        begin
            loaded_q <= 1'b1;
        end
    end

    assign o_loaded  = loaded_q;
    assign o_weights = wgt_q;

    // Source keeps its offer until the bank takes it
    a_offer_held: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_wgt_valid && !o_wgt_ready) |=> (i_wgt_valid && $stable(i_wgt_data))
    ) else $error("weight offer withdrawn or changed before it was accepted");

endmodule

// ==== source/deconv_col_core.sv ====
`timescale 1ns/1ps

module deconv_col_core
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_issue,
    input  logic                i_advance,
    input  deconv_pkg::fcol_t   i_col,
    input  deconv_pkg::wcol_t   i_wcol,
    output deconv_pkg::dcol_t   o_dcol
);

    deconv_pkg::acc_t   prod_q [deconv_pkg::FEATURE_SIZE][deconv_pkg::WEIGHT_SIZE];
    deconv_pkg::dcol_t  sum_d;
    deconv_pkg::dcol_t  dcol_q;

    // --------------------------------------------------
    // Stage 1, every pixel times every tap
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < deconv_pkg::FEATURE_SIZE; i++)
            begin
                for (int j = 0; j < deconv_pkg::WEIGHT_SIZE; j++)
                begin
                    prod_q[i][j] <= '0;
                end
            end
        end
        else if (i_issue && i_advance)
        begin
            for (int i = 0; i < deconv_pkg::FEATURE_SIZE; i++)
            begin
                for (int j = 0; j < deconv_pkg::WEIGHT_SIZE; j++)
                begin
                    prod_q[i][j] <= deconv_pkg::acc_t'(i_col.pix[i])
                                  * deconv_pkg::acc_t'(i_wcol.tap[j]);
                end
            end
        end
    end

    // --------------------------------------------------
    // Stage 2, overlap-add
    // --------------------------------------------------
    // Product (i, j) lands on output i*STRIDE + j
    always_comb
    begin
        sum_d = '0;
        for (int k = 0; k < deconv_pkg::N_PIX_OUT; k++)
        begin
            for (int i = 0; i < deconv_pkg::FEATURE_SIZE; i++)
            begin
                for (int j = 0; j < deconv_pkg::WEIGHT_SIZE; j++)
                begin
                    if (i * deconv_pkg::STRIDE + j == k)
                    begin
                        sum_d.acc[k] = sum_d.acc[k] + prod_q[i][j];
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            dcol_q <= '0;
        end
        else if (i_advance)
        begin
            dcol_q <= sum_d;
        end
    end

    assign o_dcol = dcol_q;

endmodule

// ==== source/deconv_ctrl.sv ====
`timescale 1ns/1ps

module deconv_ctrl
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_col_avail,
    input  logic    i_loaded,
    input  logic    i_res_ready,
    output logic    o_col_release,
    output logic    o_issue,
    output logic    o_advance,
    output logic    o_wgt_open,
    output logic    o_res_valid
);

    deconv_pkg::ctrl_state_e            state_q;
    logic [deconv_pkg::PIPE_DEPTH-1:0]  vld_q;
    logic                               advance;
    logic                               issue;

    // Pipeline moves unless the result at the end is stuck
    assign advance = !vld_q[deconv_pkg::PIPE_DEPTH-1] || i_res_ready;

    assign issue = (state_q == deconv_pkg::RUN) && i_loaded && i_col_avail && advance;

    assign o_issue       = issue;
    assign o_advance     = advance;
    assign o_col_release = issue;
    assign o_res_valid   = vld_q[deconv_pkg::PIPE_DEPTH-1];

    // New weights only with nothing in flight or queued
    assign o_wgt_open = (vld_q == '0) && !i_col_avail;

    // --------------------------------------------------
    // State and in-flight tracking
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q <= deconv_pkg::WAIT_WEIGHTS;
        end
        else
        begin
            case (state_q)
                deconv_pkg::WAIT_WEIGHTS:
                begin
                    if (i_loaded)
                    begin
                        state_q <= deconv_pkg::RUN;
                    end
                end
                default:
                begin
                    state_q <= deconv_pkg::RUN;
                end
            endcase
        end
    end

    // One valid bit per core stage
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            vld_q <= '0;
        end
        else if (advance)
        begin
            vld_q <= {vld_q[deconv_pkg::PIPE_DEPTH-2:0], issue};
        end
    end

    a_col_held_until_release: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_col_avail && !o_col_release) |=> i_col_avail
    ) else $error("feature column vanished before it was released");

endmodule

// ==== source/deconv_top.sv ====
`timescale 1ns/1ps

module deconv_top
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_feat_valid,
    input  deconv_pkg::pix_t                i_feat_data,
    output logic                            o_feat_ready,
    input  logic                            i_wgt_valid,
    input  deconv_pkg::weight_set_t         i_wgt_data,
    output logic                            o_wgt_ready,
    output logic                            o_res_valid,
    output deconv_pkg::deconv_result_t      o_res_data,
    input  logic                            i_res_ready
);

    logic                           feat_valid_buf;
    logic                           feat_ready_buf;
    logic                           loaded;
    logic                           col_avail;
    logic                           col_release;
    logic                           issue;
    logic                           advance;
    logic                           wgt_open;
    deconv_pkg::fcol_t              col;
    deconv_pkg::weight_set_t        weights;
    deconv_pkg::dcol_t              core_dcol [deconv_pkg::NUM_KERNELS];

    // Pixels held off until a weight set is in place
    assign feat_valid_buf = i_feat_valid && loaded;
    assign o_feat_ready   = feat_ready_buf && loaded;

    deconv_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_col_avail    (col_avail),
        .i_loaded       (loaded),
        .i_res_ready    (i_res_ready),
        .o_col_release  (col_release),
        .o_issue        (issue),
        .o_advance      (advance),
        .o_wgt_open     (wgt_open),
        .o_res_valid    (o_res_valid)
    );

    feature_pingpong_buffer u_feat_buf (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_feat_valid   (feat_valid_buf),
        .i_feat_data    (i_feat_data),
        .o_feat_ready   (feat_ready_buf),
        .i_col_release  (col_release),
        .o_col_avail    (col_avail),
        .o_col          (col)
    );

    weight_bank u_wgt_bank (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_wgt_valid    (i_wgt_valid),
        .i_wgt_data     (i_wgt_data),
        .i_wgt_open     (wgt_open),
        .o_wgt_ready    (o_wgt_ready),
        .o_loaded       (loaded),
        .o_weights      (weights)
    );

    // All cores share one feature column
    for (genvar g = 0; g < deconv_pkg::NUM_KERNELS; g++)
    begin : g_core
        deconv_col_core u_core (
            .i_clk      (i_clk),
            .i_rst_n    (i_rst_n),
            .i_issue    (issue),
            .i_advance  (advance),
            .i_col      (col),
            .i_wcol     (weights.kern[g]),
            .o_dcol     (core_dcol[g])
        );
    end

    always_comb
    begin
        for (int n = 0; n < deconv_pkg::NUM_KERNELS; n++)
        begin
            o_res_data.kern[n] = core_dcol[n];
        end
    end

endmodule

// ==== verification/tb_deconv_top.sv ====
`timescale 1ns/1ps

module tb_deconv_top;

    localparam int TIMEOUT = 2000;

    typedef enum {FEAT_READY, WGT_READY, DRAINED} wait_e;

    logic                           i_clk;
    logic                           i_rst_n;
    logic                           i_feat_valid;
    deconv_pkg::pix_t               i_feat_data;
    logic                           o_feat_ready;
    logic                           i_wgt_valid;
    deconv_pkg::weight_set_t        i_wgt_data;
    logic                           o_wgt_ready;
    logic                           o_res_valid;
    deconv_pkg::deconv_result_t     o_res_data;
    logic                           i_res_ready;

    // Reference model state
    deconv_pkg::deconv_result_t     exp_mem [128];
    deconv_pkg::deconv_result_t     exp_head;
    deconv_pkg::deconv_result_t     held_data;
    deconv_pkg::weight_set_t        ref_wgt;
    deconv_pkg::fcol_t              col_buf;
    int                             wr_cnt;
    int                             rd_cnt;
    int                             pend_cnt;
    int                             pix_idx;
    int                             check_errors;
    int                             timeout_errors;
    logic                           wgt_seen;
    logic                           bp_mode;
    logic                           timed_out;
    logic [31:0]                    data_lfsr;
    logic [31:0]                    rdy_lfsr;

    deconv_top DUT (.*);

    assign pend_cnt = wr_cnt - rd_cnt;
    assign exp_head = exp_mem[rd_cnt];

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Sink side, random stalls only in back-pressure phases
    initial
    begin
        logic [31:0] bits;
        i_res_ready = 1'b1;
        forever
        begin
            @(posedge i_clk);
            #1;
            take_bits(rdy_lfsr, 2, bits);
            i_res_ready = !bp_mode || (bits[1:0] == 2'b00);
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            v  = {v[30:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    // Output k collects every product with i*STRIDE + j == k
    function automatic deconv_pkg::deconv_result_t deconv_ref(
        input deconv_pkg::fcol_t col, input deconv_pkg::weight_set_t ws);
        deconv_pkg::deconv_result_t r;
        r = '0;
        for (int n = 0; n < deconv_pkg::NUM_KERNELS; n++)
            for (int i = 0; i < deconv_pkg::FEATURE_SIZE; i++)
                for (int j = 0; j < deconv_pkg::WEIGHT_SIZE; j++)
                    r.kern[n].acc[i * deconv_pkg::STRIDE + j] += deconv_pkg::acc_t'(col.pix[i])
                        * deconv_pkg::acc_t'(ws.kern[n].tap[j]);
        return r;
    endfunction

    task automatic report_mismatch(input string name,
                                   input logic [$bits(deconv_pkg::deconv_result_t)-1:0] expv,
                                   input logic [$bits(deconv_pkg::deconv_result_t)-1:0] actv);
        $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, expv, actv);
        check_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        check_errors++;
    endtask

    // Polls at the falling edge, where the DUT outputs are settled
    task automatic wait_until(input wait_e what, input string desc);
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (!timed_out && !((what == FEAT_READY && o_feat_ready)
                               || (what == WGT_READY && o_wgt_ready)
                               || (what == DRAINED && pend_cnt == 0)))
        begin
            waited++;
            if (waited > TIMEOUT)
            begin
                $display("Timeout: %s did not happen within %0d cycles", desc, TIMEOUT);
                timeout_errors++;
                timed_out = 1'b1;
            end
            @(negedge i_clk);
        end
    endtask

    task automatic send_pixel(input deconv_pkg::pix_t p);
        i_feat_data  = p;
        i_feat_valid = !timed_out;
        wait_until(FEAT_READY, "feature handshake");
        @(posedge i_clk);
        #1;
        i_feat_valid = 1'b0;
    endtask

    task automatic send_weights(input deconv_pkg::weight_set_t ws);
        i_wgt_data  = ws;
        i_wgt_valid = !timed_out;
        wait_until(WGT_READY, "weight handshake");
        @(posedge i_clk);
        #1;
        i_wgt_valid = 1'b0;
    endtask

    task automatic send_random_columns(input int n);
        logic [31:0] v;
        repeat (n * deconv_pkg::FEATURE_SIZE)
        begin
            take_bits(data_lfsr, 16, v);
            send_pixel(v[15:0]);
        end
    endtask

    task automatic drain();
        wait_until(DRAINED, "drain of pending results");
        @(posedge i_clk);
        #1;
    endtask

    // --------------------------------------------------
    // Reference queue, filled at each completed column
    // --------------------------------------------------
    always @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_cnt   <= 0;
            rd_cnt   <= 0;
            pix_idx  <= 0;
            wgt_seen <= 1'b0;
        end
        else
        begin
            if (i_wgt_valid && o_wgt_ready)
            begin
                ref_wgt  <= i_wgt_data;
                wgt_seen <= 1'b1;
            end
            if (i_feat_valid && o_feat_ready)
            begin
                col_buf.pix[pix_idx] = i_feat_data;
                pix_idx <= (pix_idx + 1) % deconv_pkg::FEATURE_SIZE;
                if (pix_idx == deconv_pkg::FEATURE_SIZE - 1)
                begin
                    exp_mem[wr_cnt] <= deconv_ref(col_buf, ref_wgt);
                    wr_cnt          <= wr_cnt + 1;
                end
            end
            if (o_res_valid && i_res_ready)
                rd_cnt <= rd_cnt + 1;
            held_data <= o_res_data;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_idle_before_weights: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !wgt_seen |-> (!o_res_valid && !o_feat_ready && o_wgt_ready))
        else report_failure("outputs not idle while no weight set is loaded");

    a_res_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_res_valid && i_res_ready) |-> o_res_data == exp_head)
        else report_mismatch("o_res_data", $sampled(exp_head), $sampled(o_res_data));

    a_res_valid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_res_valid && !i_res_ready) |=> o_res_valid)
        else report_failure("o_res_valid dropped before the result was accepted");

    a_res_data_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_res_valid && !i_res_ready) |=> o_res_data == held_data)
        else report_mismatch("o_res_data", $sampled(held_data), $sampled(o_res_data));

    a_wgt_ready_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wgt_ready |-> pend_cnt == 0)
        else report_failure("o_wgt_ready high while a result is still pending");

    a_feat_stall_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (wgt_seen && pend_cnt == deconv_pkg::PIPE_DEPTH + 2) |-> !o_feat_ready)
        else report_mismatch("o_feat_ready", 0, $sampled(o_feat_ready));

    a_feat_stall_cause: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (wgt_seen && !o_feat_ready) |-> pend_cnt >= 2)
        else report_failure("o_feat_ready low although a feature bank is free");

    initial
    begin
        deconv_pkg::weight_set_t ws;
        logic [31:0] v;
        check_errors   = 0;
        timeout_errors = 0;
        timed_out      = 1'b0;
        bp_mode        = 1'b0;
        data_lfsr      = 32'h5eb2;
        rdy_lfsr       = 32'h5eb2;
        i_rst_n        = 1'b0;
        i_feat_valid   = 1'b0;
        i_feat_data    = '0;
        i_wgt_valid    = 1'b0;
        i_wgt_data     = '0;
        repeat (8) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        // Pixels offered before any weights must be refused
        i_feat_valid = 1'b1;
        i_feat_data  = 16'sd9;
        repeat (10) @(posedge i_clk);
        #1;
        i_feat_valid = 1'b0;

        // Fixed set with negative values, taps from j = 2 down to 0
        ws.kern[0].tap = {16'sd3, 16'sd2, 16'sd1};
        ws.kern[1].tap = {16'sd5, 16'sd0, -16'sd1};
        ws.kern[2].tap = {-16'sd2, 16'sd32767, 16'sh8000};
        ws.kern[3].tap = {16'sd300, -16'sd200, 16'sd100};
        send_weights(ws);
        send_pixel(-16'sd3);
        send_pixel(16'sd7);
        drain();

        send_random_columns(40);
        drain();

        bp_mode = 1'b1;
        send_random_columns(40);
        drain();

        // New random set once the pipeline is empty
        for (int w = 0; w < $bits(ws) / 32; w++)
        begin
            take_bits(data_lfsr, 32, v);
            ws[w*32 +: 32] = v;
        end
        send_weights(ws);
        send_random_columns(10);
        drain();
        bp_mode = 1'b0;
        repeat (4) @(posedge i_clk);

        $display("Errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== sim.f ====
source/deconv_pkg.sv
source/feature_pingpong_buffer.sv
source/weight_bank.sv
source/deconv_col_core.sv
source/deconv_ctrl.sv
source/deconv_top.sv
verification/tb_deconv_top.sv
